// File: design/agu_bank_map.sv
// combinational on stage 1; the run of banks wraps modulo 32 and split marks the wrap
`default_nettype none

module agu_bank_map (
  input  logic                 req_valid,
  input  agu_pkg::op_t         req_op,
  input  agu_pkg::vaddr_t      req_addr,
  input  agu_pkg::bank_mask_t  other0_banks,
  input  agu_pkg::bank_mask_t  other1_banks,
  input  agu_pkg::bank_mask_t  otherr_banks,
  input  logic                 other_flip,
  output agu_pkg::bank_mask_t  banks,
  output logic                 split,
  output logic                 bank_conflict
);

  import agu_pkg::*;

  byte_count_t byte_count;
  logic [4:0]  span_bytes;
  logic [2:0]  bank_run;
  bank_idx_t   first_bank;
  bank_mask_t  run_base;
  logic [2*bank_count-1:0] run_wide;
  bank_mask_t  all_banks;
  bank_mask_t  other_sel;
  bank_mask_t  hit_banks;

  assign byte_count = size_bytes(req_op[3:1]);
  assign first_bank = req_addr[6:2];

  // offset inside the first bank plus the access length, at most 3 + 16
  assign span_bytes = 5'(req_addr[1:0]) + byte_count;

  // whole banks touched, rounded up
  assign bank_run = 3'((span_bytes + 5'(bank_bytes - 1)) / 5'(bank_bytes));

  // contiguous run of ones starting at bank 0
  assign run_base = bank_mask_t'((32'd1 << bank_run) - 32'd1);

  // shift in a double width vector, upper half is the wrapped part
  assign run_wide = {bank_mask_t'(0), run_base} << first_bank;

  assign all_banks = run_wide[bank_count-1:0] | run_wide[2*bank_count-1:bank_count];
  assign split     = |run_wide[2*bank_count-1:bank_count];

  // two-port select: flip picks which neighbour port to compare with
  assign other_sel = other_flip ? other1_banks : other0_banks;
  assign hit_banks = all_banks & (otherr_banks | other_sel);

  assign bank_conflict = req_valid && (|hit_banks);

  // conflicting banks are dropped from the issued set
  assign banks = req_valid ? (all_banks & ~hit_banks) : '0;

  // a 16 byte access at an odd offset is the widest case, five banks
  always_comb begin
    if (req_valid) begin
      a_bank_run_size : assert final ($countones(all_banks) inside {[1:5]})
        else $error("bank run covers %0d banks", $countones(all_banks));
    end
  end

endmodule

`default_nettype wire

// File: design/agu_pkg.sv
// shared widths for one load/store port; bank geometry is fixed at 32 banks of 4 bytes
`default_nettype none

package agu_pkg;

  localparam int bank_count       = 32;
  localparam int bank_bytes       = 4;
  localparam int thread_count     = 2;
  localparam int page_offset_bits = 13;

  // address geometry
  localparam int vaddr_bits  = 44;
  localparam int tlb_id_bits = 21;

  typedef logic [vaddr_bits-1:0]                              vaddr_t;
  typedef logic [vaddr_bits-1:0]                              paddr_t;
  typedef logic [vaddr_bits-page_offset_bits-1:0]             ppage_t;
  typedef logic [tlb_id_bits+vaddr_bits-page_offset_bits-1:0] tlb_addr_t;
  typedef logic [23:0]                                        page_id_t;

  // bit 0 store, bits 3:1 size code, upper bits spare
  typedef logic [7:0] op_t;

  typedef logic [bank_count-1:0]         bank_mask_t;
  typedef logic [$clog2(bank_count)-1:0] bank_idx_t;
  typedef logic [8:0]                    reg_no_t;
  typedef logic [8:0]                    lsq_tag_t;

  // size code and decoded byte count
  typedef logic [2:0] size_code_t;
  typedef logic [4:0] byte_count_t;

  typedef enum logic [1:0] {
    fault_none,
    fault_bus_error,
    fault_tlb_miss,
    fault_priv
  } fault_t;

  // codes 5..7 fall back to 8 bytes
  function automatic byte_count_t size_bytes(input size_code_t code);
    case (code)
      3'd0:    size_bytes = 5'd1;
      3'd1:    size_bytes = 5'd2;
      3'd2:    size_bytes = 5'd4;
      3'd3:    size_bytes = 5'd8;
      3'd4:    size_bytes = 5'd16;
      default: size_bytes = 5'd8;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/agu_req_stage.sv
// stage 1 of the port; holds on stall, except drops the valid bit, csr writes ignore stall
`default_nettype none

module agu_req_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall,
  input  logic                except,
  input  logic                in_en,
  input  agu_pkg::op_t        in_op,
  input  agu_pkg::vaddr_t     in_addr,
  input  logic                in_thread,
  input  logic                in_user,
  input  logic                in_error,
  input  agu_pkg::reg_no_t    in_reg,
  input  agu_pkg::lsq_tag_t   in_tag,
  input  logic                csr_en,
  input  logic                csr_thread,
  input  agu_pkg::page_id_t   csr_data,
  output logic                req_valid,
  output agu_pkg::op_t        req_op,
  output agu_pkg::vaddr_t     req_addr,
  output logic                req_thread,
  output logic                req_user,
  output logic                req_error,
  output agu_pkg::reg_no_t    req_reg,
  output agu_pkg::lsq_tag_t   req_tag,
  output agu_pkg::tlb_addr_t  tlb_addr
);

  import agu_pkg::*;

  // one page identifier per hardware thread
  page_id_t page_id [thread_count];

  // valid bit of stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else if (except) begin
      req_valid <= 1'b0;
    end else if (!stall) begin
      req_valid <= in_en;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      req_op     <= in_op;
      req_addr   <= in_addr;
      req_thread <= in_thread;
      req_user   <= in_user;
      req_error  <= in_error;
      req_reg    <= in_reg;
      req_tag    <= in_tag;
    end
  end

  // csr strobe writes the selected thread's page identifier
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < thread_count; t++) begin
        page_id[t] <= '0;
      end
    end else if (csr_en) begin
      page_id[csr_thread] <= csr_data;
    end
  end

  // lookup key: low identifier bits above the virtual page number
  assign tlb_addr = {page_id[req_thread][tlb_id_bits-1:0],
                     req_addr[vaddr_bits-1:page_offset_bits]};

  // except must empty stage 1 even while the pipe is stalled
  a_except_kills_stage1 : assert property (
    @(posedge clk) disable iff (rst)
    except |=> !req_valid
  ) else $error("stage 1 still valid after except");

endmodule

`default_nettype wire

// File: design/agu_resp_stage.sv
// stage 2 of the port; the TLB answer must be valid in the same cycle as stage 1
`default_nettype none

module agu_resp_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stall,
  input  logic                 except,
  input  logic                 req_valid,
  input  agu_pkg::op_t         req_op,
  input  agu_pkg::vaddr_t      req_addr,
  input  logic                 req_thread,
  input  logic                 req_user,
  input  logic                 req_error,
  input  agu_pkg::reg_no_t     req_reg,
  input  agu_pkg::lsq_tag_t    req_tag,
  input  agu_pkg::bank_mask_t  banks,
  input  logic                 split,
  input  logic                 bank_conflict,
  input  logic                 tlb_hit,
  input  agu_pkg::ppage_t      tlb_ppage,
  input  logic                 tlb_user_ok,
  output logic                 mop_en,
  output logic                 mop_st,
  output agu_pkg::size_code_t  mop_size,
  output agu_pkg::reg_no_t     mop_reg,
  output agu_pkg::lsq_tag_t    mop_tag,
  output logic                 mop_thread,
  output agu_pkg::paddr_t      mop_addr,
  output agu_pkg::bank_mask_t  mop_banks,
  output logic                 mop_split,
  output logic                 conflict,
  output logic                 fault,
  output agu_pkg::fault_t      fault_kind
);

  import agu_pkg::*;

  fault_t fault_next;
  logic   has_fault;

  // bus error wins over miss, miss wins over privilege
  always_comb begin
    if (req_error) begin
      fault_next = fault_bus_error;
    end else if (!tlb_hit) begin
      fault_next = fault_tlb_miss;
    end else if (req_user && !tlb_user_ok) begin
      fault_next = fault_priv;
    end else begin
      fault_next = fault_none;
    end
  end

  assign has_fault = (fault_next != fault_none);

  always_ff @(posedge clk) begin
    if (rst) begin
      mop_en     <= 1'b0;
      fault      <= 1'b0;
      conflict   <= 1'b0;
      fault_kind <= fault_none;
    end else if (except) begin
      mop_en     <= 1'b0;
      fault      <= 1'b0;
      conflict   <= 1'b0;
      fault_kind <= fault_none;
    end else if (!stall) begin
      mop_en     <= req_valid && !has_fault && !bank_conflict;
      fault      <= req_valid && has_fault;
      conflict   <= req_valid && !has_fault && bank_conflict;
      fault_kind <= req_valid ? fault_next : fault_none;
    end
  end

  // operation payload, physical page above the untranslated offset
  always_ff @(posedge clk) begin
    if (!stall) begin
      mop_st     <= req_op[0];
      mop_size   <= req_op[3:1];
      mop_reg    <= req_reg;
      mop_tag    <= req_tag;
      mop_thread <= req_thread;
      mop_addr   <= {tlb_ppage, req_addr[page_offset_bits-1:0]};
      mop_banks  <= banks;
      mop_split  <= split;
    end
  end

  a_issue_or_fault : assert property (
    @(posedge clk) disable iff (rst)
    !(mop_en && fault)
  ) else $error("memory op issued together with a fault");

endmodule

`default_nettype wire

// File: design/agu_top.sv
// address stage of one load/store port; two edges of latency, stall is the only back-pressure
`default_nettype none

module agu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_en,
  input  agu_pkg::op_t         in_op,
  input  agu_pkg::vaddr_t      in_addr,
  input  logic                 in_thread,
  input  logic                 in_user,
  input  agu_pkg::reg_no_t     in_reg,
  input  agu_pkg::lsq_tag_t    in_tag,
  input  logic                 in_error,
  input  logic                 stall,
  input  logic                 except,
  input  logic                 csr_en,
  input  logic                 csr_thread,
  input  agu_pkg::page_id_t    csr_data,
  input  agu_pkg::bank_mask_t  other0_banks,
  input  agu_pkg::bank_mask_t  other1_banks,
  input  agu_pkg::bank_mask_t  otherr_banks,
  input  logic                 other_flip,
  input  logic                 tlb_hit,
  input  agu_pkg::ppage_t      tlb_ppage,
  input  logic                 tlb_user_ok,
  output logic                 tlb_rd,
  output agu_pkg::tlb_addr_t   tlb_addr,
  output logic                 mop_en,
  output logic                 mop_st,
  output agu_pkg::size_code_t  mop_size,
  output agu_pkg::reg_no_t     mop_reg,
  output agu_pkg::lsq_tag_t    mop_tag,
  output logic                 mop_thread,
  output agu_pkg::paddr_t      mop_addr,
  output agu_pkg::bank_mask_t  mop_banks,
  output logic                 mop_split,
  output logic                 conflict,
  output logic                 fault,
  output agu_pkg::fault_t      fault_kind
);

  import agu_pkg::*;

  // stage 1 request
  logic       req_valid;
  op_t        req_op;
  vaddr_t     req_addr;
  logic       req_thread;
  logic       req_user;
  logic       req_error;
  reg_no_t    req_reg;
  lsq_tag_t   req_tag;

  // bank map results
  bank_mask_t banks;
  logic       split;
  logic       bank_conflict;

  // lookup runs whenever stage 1 holds a request
  assign tlb_rd = req_valid;

  agu_req_stage u_req (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .except     (except),
    .in_en      (in_en),
    .in_op      (in_op),
    .in_addr    (in_addr),
    .in_thread  (in_thread),
    .in_user    (in_user),
    .in_error   (in_error),
    .in_reg     (in_reg),
    .in_tag     (in_tag),
    .csr_en     (csr_en),
    .csr_thread (csr_thread),
    .csr_data   (csr_data),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_thread (req_thread),
    .req_user   (req_user),
    .req_error  (req_error),
    .req_reg    (req_reg),
    .req_tag    (req_tag),
    .tlb_addr   (tlb_addr)
  );

  agu_bank_map u_banks (
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .other0_banks  (other0_banks),
    .other1_banks  (other1_banks),
    .otherr_banks  (otherr_banks),
    .other_flip    (other_flip),
    .banks         (banks),
    .split         (split),
    .bank_conflict (bank_conflict)
  );

  agu_resp_stage u_resp (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .except        (except),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_addr      (req_addr),
    .req_thread    (req_thread),
    .req_user      (req_user),
    .req_error     (req_error),
    .req_reg       (req_reg),
    .req_tag       (req_tag),
    .banks         (banks),
    .split         (split),
    .bank_conflict (bank_conflict),
    .tlb_hit       (tlb_hit),
    .tlb_ppage     (tlb_ppage),
    .tlb_user_ok   (tlb_user_ok),
    .mop_en        (mop_en),
    .mop_st        (mop_st),
    .mop_size      (mop_size),
    .mop_reg       (mop_reg),
    .mop_tag       (mop_tag),
    .mop_thread    (mop_thread),
    .mop_addr      (mop_addr),
    .mop_banks     (mop_banks),
    .mop_split     (mop_split),
    .conflict      (conflict),
    .fault         (fault),
    .fault_kind    (fault_kind)
  );

endmodule

`default_nettype wire

// File: files.f
design/agu_pkg.sv
design/agu_req_stage.sv
design/agu_bank_map.sv
design/agu_resp_stage.sv
design/agu_top.sv
testbench/agu_checker.sv
testbench/tb_agu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds tb_agu with verilator, runs it and checks the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_tb_agu
log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_agu --Mdir "$build_dir" -o "$sim_bin" -f files.f; then
  echo "build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$log"; then
  exit 0
fi
exit 1

// File: testbench/agu_checker.sv
// predicts port outputs from the driven inputs; its TLB rule must match the model in tb_agu
`default_nettype none

module agu_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_en,
  input  agu_pkg::op_t         in_op,
  input  agu_pkg::vaddr_t      in_addr,
  input  logic                 in_thread,
  input  logic                 in_user,
  input  logic                 in_error,
  input  agu_pkg::reg_no_t     in_reg,
  input  agu_pkg::lsq_tag_t    in_tag,
  input  logic                 stall,
  input  logic                 except,
  input  logic                 csr_en,
  input  logic                 csr_thread,
  input  agu_pkg::page_id_t    csr_data,
  input  agu_pkg::bank_mask_t  other0_banks,
  input  agu_pkg::bank_mask_t  other1_banks,
  input  agu_pkg::bank_mask_t  otherr_banks,
  input  logic                 other_flip,
  input  logic                 tlb_rd,
  input  agu_pkg::tlb_addr_t   tlb_addr,
  input  logic                 mop_en,
  input  logic                 mop_st,
  input  agu_pkg::size_code_t  mop_size,
  input  agu_pkg::reg_no_t     mop_reg,
  input  agu_pkg::lsq_tag_t    mop_tag,
  input  logic                 mop_thread,
  input  agu_pkg::paddr_t      mop_addr,
  input  agu_pkg::bank_mask_t  mop_banks,
  input  logic                 mop_split,
  input  logic                 conflict,
  input  logic                 fault,
  input  agu_pkg::fault_t      fault_kind,
  output int                   errors
);

  timeunit 1ns;
  timeprecision 1ps;

  import agu_pkg::*;

  int error_count = 0;

  // first history entry, the request now in stage 1
  logic       s1_valid;
  op_t        s1_op;
  vaddr_t     s1_addr;
  logic       s1_thread;
  logic       s1_user;
  logic       s1_error;
  reg_no_t    s1_reg;
  lsq_tag_t   s1_tag;

  // second entry, what stage 2 should show
  logic       s2_valid;
  logic       s2_st;
  size_code_t s2_size;
  logic       s2_thread;
  logic       s2_split;
  logic       s2_conf;
  reg_no_t    s2_reg;
  lsq_tag_t   s2_tag;
  paddr_t     s2_addr;
  bank_mask_t s2_banks;
  fault_t     s2_kind;

  page_id_t   page_id [2];
  tlb_addr_t  exp_key;
  logic       exp_clean;
  logic       exp_mop_en;
  logic       exp_fault;
  logic       exp_conflict;
  fault_t     exp_kind;

  // run of 4-byte banks from the start bank, counted modulo 32
  function automatic void bank_run(input op_t op, input vaddr_t addr,
                                   output bank_mask_t mask, output logic wraps);
    int nbytes;
    int nbanks;
    int first;
    case (op[3:1])
      3'd0:    nbytes = 1;
      3'd1:    nbytes = 2;
      3'd2:    nbytes = 4;
      3'd3:    nbytes = 8;
      3'd4:    nbytes = 16;
      default: nbytes = 8;
    endcase
    nbanks = (int'(addr[1:0]) + nbytes + 3) / 4;
    first  = int'(addr[6:2]);
    mask   = '0;
    wraps  = 1'b0;
    for (int i = 0; i < nbanks; i++) begin
      mask[5'((first + i) % 32)] = 1'b1;
      if (first + i > 31) begin
        wraps = 1'b1;
      end
    end
  endfunction

  // TLB model: bit 13 of the key misses, bit 14 marks a supervisor page
  function automatic fault_t classify(input logic error, input logic user,
                                      input tlb_addr_t key);
    if (error) return fault_bus_error;
    if (key[13]) return fault_tlb_miss;
    if (user && key[14]) return fault_priv;
    return fault_none;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    error_count++;
  endtask

  assign exp_key = {page_id[s1_thread][20:0], s1_addr[43:13]};

  always @(posedge clk) begin
    bank_mask_t run;
    bank_mask_t hit;
    logic       wraps;
    if (rst) begin
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      page_id[0] <= '0;
      page_id[1] <= '0;
    end else begin
      if (csr_en) begin
        page_id[csr_thread] <= csr_data;
      end
      if (except) begin
        s1_valid <= 1'b0;
        s2_valid <= 1'b0;
      end else if (!stall) begin
        bank_run(s1_op, s1_addr, run, wraps);
        // neighbour masks are seen while the request sits in stage 1
        hit = run & (otherr_banks | (other_flip ? other1_banks : other0_banks));
        s2_valid  <= s1_valid;
        s2_st     <= s1_op[0];
        s2_size   <= s1_op[3:1];
        s2_thread <= s1_thread;
        s2_reg    <= s1_reg;
        s2_tag    <= s1_tag;
        s2_addr   <= {~exp_key[30:0], s1_addr[12:0]};
        s2_kind   <= classify(s1_error, s1_user, exp_key);
        s2_banks  <= run & ~hit;
        s2_split  <= wraps;
        s2_conf   <= |hit;
        s1_valid  <= in_en;
        s1_op     <= in_op;
        s1_addr   <= in_addr;
        s1_thread <= in_thread;
        s1_user   <= in_user;
        s1_error  <= in_error;
        s1_reg    <= in_reg;
        s1_tag    <= in_tag;
      end
    end
  end

  assign exp_clean    = s2_valid && (s2_kind == fault_none);
  assign exp_mop_en   = exp_clean && !s2_conf;
  assign exp_conflict = exp_clean && s2_conf;
  assign exp_fault    = s2_valid && (s2_kind != fault_none);
  assign exp_kind     = s2_valid ? s2_kind : fault_none;
  assign errors       = error_count;

  // sampled mid-cycle, away from the edges where registers and inputs change
  a_tlb_rd : assert property (@(negedge clk) disable iff (rst) tlb_rd == s1_valid)
    else report_mismatch("tlb_rd", 64'(s1_valid), 64'(tlb_rd));
  a_tlb_addr : assert property (@(negedge clk) disable iff (rst) !s1_valid || tlb_addr == exp_key)
    else report_mismatch("tlb_addr", 64'(exp_key), 64'(tlb_addr));
  a_mop_en : assert property (@(negedge clk) disable iff (rst) mop_en == exp_mop_en)
    else report_mismatch("mop_en", 64'(exp_mop_en), 64'(mop_en));
  a_fault : assert property (@(negedge clk) disable iff (rst) fault == exp_fault)
    else report_mismatch("fault", 64'(exp_fault), 64'(fault));
  a_fault_kind : assert property (@(negedge clk) disable iff (rst) fault_kind == exp_kind)
    else report_mismatch("fault_kind", 64'(exp_kind), 64'(fault_kind));
  a_conflict : assert property (@(negedge clk) disable iff (rst) conflict == exp_conflict)
    else report_mismatch("conflict", 64'(exp_conflict), 64'(conflict));
  a_mop_banks : assert property (@(negedge clk) disable iff (rst)
    !exp_clean || mop_banks == s2_banks)
    else report_mismatch("mop_banks", 64'(s2_banks), 64'(mop_banks));
  a_mop_split : assert property (@(negedge clk) disable iff (rst)
    !exp_clean || mop_split == s2_split)
    else report_mismatch("mop_split", 64'(s2_split), 64'(mop_split));
  a_mop_addr : assert property (@(negedge clk) disable iff (rst)
    !exp_mop_en || mop_addr == s2_addr)
    else report_mismatch("mop_addr", 64'(s2_addr), 64'(mop_addr));
  a_mop_tag : assert property (@(negedge clk) disable iff (rst)
    !exp_mop_en || mop_tag == s2_tag)
    else report_mismatch("mop_tag", 64'(s2_tag), 64'(mop_tag));
  a_mop_reg : assert property (@(negedge clk) disable iff (rst)
    !exp_mop_en || mop_reg == s2_reg)
    else report_mismatch("mop_reg", 64'(s2_reg), 64'(mop_reg));
  a_mop_st : assert property (@(negedge clk) disable iff (rst)
    !exp_mop_en || mop_st == s2_st)
    else report_mismatch("mop_st", 64'(s2_st), 64'(mop_st));
  a_mop_size : assert property (@(negedge clk) disable iff (rst)
    !exp_mop_en || mop_size == s2_size)
    else report_mismatch("mop_size", 64'(s2_size), 64'(mop_size));
  a_mop_thread : assert property (@(negedge clk) disable iff (rst)
    !exp_mop_en || mop_thread == s2_thread)
    else report_mismatch("mop_thread", 64'(s2_thread), 64'(mop_thread));

endmodule

`default_nettype wire

// File: testbench/tb_agu.sv
// drives the port through six tests; agu_checker does all output checking
`default_nettype none

module tb_agu;

  timeunit 1ns;
  timeprecision 1ps;

  import agu_pkg::*;

  localparam int reset_cycles = 5;
  // per test: banks, translation, page ids, faults, conflict, stall and except
  localparam int test_cycles  = 56 + 12 + 11 + 9 + 16 + 23;
  localparam int cycle_limit  = 2 * (reset_cycles + test_cycles);

  logic       clk = 1'b0;
  logic       rst;
  logic       in_en;
  op_t        in_op;
  vaddr_t     in_addr;
  logic       in_thread;
  logic       in_user;
  logic       in_error;
  reg_no_t    in_reg;
  lsq_tag_t   in_tag;
  logic       stall;
  logic       except;
  logic       csr_en;
  logic       csr_thread;
  page_id_t   csr_data;
  bank_mask_t other0_banks;
  bank_mask_t other1_banks;
  bank_mask_t otherr_banks;
  logic       other_flip;
  logic       tlb_hit;
  ppage_t     tlb_ppage;
  logic       tlb_user_ok;
  logic       tlb_rd;
  tlb_addr_t  tlb_addr;
  logic       mop_en;
  logic       mop_st;
  size_code_t mop_size;
  reg_no_t    mop_reg;
  lsq_tag_t   mop_tag;
  logic       mop_thread;
  paddr_t     mop_addr;
  bank_mask_t mop_banks;
  logic       mop_split;
  logic       conflict;
  logic       fault;
  fault_t     fault_kind;

  int seed = 68334;
  int cycles = 0;
  int chk_errors;
  int tests_run = 0;
  int tests_bad = 0;
  int errors_before = 0;

  agu_top dut (.*);

  agu_checker chk (.*, .errors(chk_errors));

  always #50 clk = ~clk;

  // TLB answers from the lookup key alone, in the same cycle
  always_comb begin
    tlb_hit     = !tlb_addr[13];
    tlb_ppage   = ~tlb_addr[30:0];
    tlb_user_ok = !tlb_addr[14];
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // address bit 26 lands on key bit 13 (miss), bit 27 on key bit 14 (supervisor)
  function automatic vaddr_t rand_addr(input logic user_ok);
    vaddr_t a;
    a = {12'($random(seed)), 32'($random(seed))};
    a[26] = 1'b0;
    a[27] = !user_ok;
    return a;
  endfunction

  task automatic issue(input op_t op, input vaddr_t addr, input logic thread,
                       input logic user, input logic error);
    next_cycle();
    in_en     = 1'b1;
    in_op     = op;
    in_addr   = addr;
    in_thread = thread;
    in_user   = user;
    in_error  = error;
    in_reg    = reg_no_t'($random(seed));
    in_tag    = in_tag + 9'd1;
  endtask

  task automatic issue_at(input size_code_t code, input bank_idx_t bank,
                          input logic [1:0] offset);
    vaddr_t a;
    a = rand_addr(1'b1);
    a[6:0] = {bank, offset};
    issue({4'h0, code, 1'b0}, a, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
      in_en  = 1'b0;
      csr_en = 1'b0;
    end
  endtask

  // 16 bytes over banks 3..6 against the given neighbour masks
  task automatic conflict_case(input bank_mask_t o0, input bank_mask_t o1,
                               input bank_mask_t orr, input logic flip);
    other0_banks = o0;
    other1_banks = o1;
    otherr_banks = orr;
    other_flip   = flip;
    issue_at(3'd4, 5'd3, 2'd0);
    idle(2);
  endtask

  task automatic finish_test(input string name);
    idle(4);
    tests_run++;
    if (chk_errors != errors_before) begin
      tests_bad++;
      $display("test %s: %0d assertion errors", name, chk_errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
    errors_before = chk_errors;
  endtask

  initial begin
    vaddr_t a;
    rst          = 1'b1;
    in_en        = 1'b0;
    in_op        = '0;
    in_addr      = '0;
    in_thread    = 1'b0;
    in_user      = 1'b0;
    in_error     = 1'b0;
    in_reg       = '0;
    in_tag       = '0;
    stall        = 1'b0;
    except       = 1'b0;
    csr_en       = 1'b0;
    csr_thread   = 1'b0;
    csr_data     = '0;
    other0_banks = '0;
    other1_banks = '0;
    otherr_banks = '0;
    other_flip   = 1'b0;
    repeat (reset_cycles) next_cycle();
    rst = 1'b0;

    for (int code = 0; code < 8; code++) begin
      for (int k = 0; k < 6; k++) begin
        issue({4'h0, 3'(code), 1'($random(seed))}, rand_addr(1'b1), 1'(k), 1'b0, 1'b0);
      end
    end
    // wrap cases at the top of the bank range
    issue_at(3'd4, 5'd30, 2'd0);
    issue_at(3'd4, 5'd30, 2'd1);
    issue_at(3'd2, 5'd31, 2'd2);
    issue_at(3'd2, 5'd31, 2'd0);
    finish_test("bank_map");

    for (int i = 0; i < 8; i++) begin
      issue({4'h0, 3'(i % 5), 1'(i)}, rand_addr(1'b1), 1'(i), 1'(i / 4), 1'b0);
    end
    finish_test("translation");

    next_cycle();
    csr_en     = 1'b1;
    csr_thread = 1'b0;
    csr_data   = 24'h5a1c3e;
    next_cycle();
    csr_thread = 1'b1;
    csr_data   = 24'h1e77b2;
    next_cycle();
    csr_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      issue(8'h04, rand_addr(1'b1), 1'(i), 1'b0, 1'b0);
    end
    finish_test("page_id");

    a = rand_addr(1'b0);
    a[26] = 1'b1;
    // bus error outranks miss and privilege
    issue(8'h05, a, 1'b0, 1'b1, 1'b1);
    issue(8'h04, a, 1'b1, 1'b1, 1'b0);
    issue(8'h06, rand_addr(1'b0), 1'b0, 1'b1, 1'b0);
    issue(8'h06, rand_addr(1'b0), 1'b1, 1'b0, 1'b0);
    issue(8'h07, rand_addr(1'b1), 1'b0, 1'b1, 1'b0);
    finish_test("faults");

    conflict_case(32'h0000_0030, 32'h0010_0000, 32'h0, 1'b0);
    conflict_case(32'h0000_0030, 32'h0000_0040, 32'h0, 1'b1);
    conflict_case(32'h0000_0030, 32'h0, 32'h0, 1'b1);
    conflict_case(32'h0, 32'h0, 32'h0000_0008, 1'b0);
    other0_banks = '0;
    otherr_banks = '0;
    finish_test("conflict");

    issue_at(3'd3, 5'd7, 2'd1);
    issue_at(3'd2, 5'd9, 2'd0);
    issue_at(3'd1, 5'd11, 2'd3);
    // third request waits at the inputs while both stages hold
    stall = 1'b1;
    repeat (4) next_cycle();
    stall = 1'b0;
    idle(3);
    issue_at(3'd2, 5'd1, 2'd0);
    issue(8'h04, rand_addr(1'b1), 1'b0, 1'b0, 1'b1);
    next_cycle();
    in_en  = 1'b0;
    except = 1'b1;
    next_cycle();
    except = 1'b0;
    // except lands while stalled
    issue_at(3'd3, 5'd20, 2'd0);
    issue_at(3'd0, 5'd21, 2'd2);
    next_cycle();
    in_en = 1'b0;
    stall = 1'b1;
    next_cycle();
    except = 1'b1;
    next_cycle();
    except = 1'b0;
    stall  = 1'b0;
    finish_test("stall_except");

    $display("summary: %0d tests, %0d failing, %0d assertion errors",
             tests_run, tests_bad, chk_errors);
    if (tests_bad == 0 && chk_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
